// File: all.f
+incdir+.
csr_pkg.sv
stl_reg.sv
csr_alu.sv
clint.sv
trap_ctrl.sv
csrfile.sv
csr_top.sv
tb_csr_top.sv

// File: clint.sv
`include "csr_consts.svh"

module clint (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_wen,
  input  logic           i_sel,    // mtime or mtimecmp
  input  csr_pkg::xlen_t i_wdata,
  output logic           o_mtip
);

  csr_pkg::xlen_t mtime;
  csr_pkg::xlen_t mtimecmp;
  logic           wen_mtime;
  logic           wen_mtimecmp;

  assign wen_mtime    = i_wen && (i_sel == `CLINT_SEL_MTIME);
  assign wen_mtimecmp = i_wen && (i_sel == `CLINT_SEL_MTIMECMP);

  // free running timer, a write loads it
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mtime <= '0;
    end else if (wen_mtime) begin
      mtime <= i_wdata;
    end else begin
      mtime <= mtime + `CPU_WIDTH'd1;
    end
  end

  // all ones keeps the timer quiet out of reset
  stl_reg #(.T(csr_pkg::xlen_t), .RESET_VAL('1)) mtimecmp_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (wen_mtimecmp),
    .i_din  (i_wdata),
    .o_dout (mtimecmp)
  );

  // pending lags the compare by one cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mtip <= 1'b0;
    end else begin
      o_mtip <= (mtime >= mtimecmp);
    end
  end

  // first compare out of reset sees the reset values of mtime and mtimecmp
  a_mtip_quiet_after_rst: assert property (
    @(posedge i_clk) $fell(i_rst) |=> !o_mtip
  ) else $error("clint: mtip set in the first cycle out of reset");

endmodule

// File: csr_alu.sv
`include "csr_consts.svh"

module csr_alu (
  input  logic               i_valid,
  input  csr_pkg::csr_op_e   i_op,
  input  csr_pkg::csr_addr_t i_addr,
  input  csr_pkg::xlen_t     i_src,   // rs1 value
  input  csr_pkg::xlen_t     i_old,   // current csr value
  output logic               o_wen,
  output csr_pkg::csr_addr_t o_waddr,
  output csr_pkg::xlen_t     o_wdata
);

  assign o_wen   = i_valid;  // every csr op writes back
  assign o_waddr = i_addr;

  always_comb begin
    case (i_op)
      csr_pkg::CSR_RW: o_wdata = i_src;
      csr_pkg::CSR_RS: o_wdata = i_old | i_src;   // set bits
      csr_pkg::CSR_RC: o_wdata = i_old & ~i_src;  // clear bits
      default:         o_wdata = i_old;           // keep value
    endcase
  end

endmodule

// File: csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CPU_WIDTH 64
`define CSR_ADDRW 12

// machine mode csr addresses
`define ADDR_MSTATUS  12'h300
`define ADDR_MIE      12'h304
`define ADDR_MTVEC    12'h305
`define ADDR_MSCRATCH 12'h340
`define ADDR_MEPC     12'h341
`define ADDR_MCAUSE   12'h342
`define ADDR_MIP      12'h344
`define ADDR_MCYCLE   12'hB00

// mstatus fields
`define M_STATUS_MIE  3
`define M_STATUS_MPIE 7
`define M_STATUS_VS   10:9
`define M_STATUS_MPP  12:11
`define M_STATUS_FS   14:13
`define M_STATUS_XS   16:15
`define M_STATUS_SD   63

`define M_MIP_MTIP 7  // timer pending, driven by clint
`define M_MIE_MTIE 7

// trap causes
`define CAUSE_ECALL_M 64'd11
`define CAUSE_MTIMER  64'h8000_0000_0000_0007  // interrupt bit + code 7

// clint write select
`define CLINT_SEL_MTIME    1'b0
`define CLINT_SEL_MTIMECMP 1'b1

`endif

// File: csr_pkg.sv
`include "csr_consts.svh"

package csr_pkg;

  typedef logic [`CPU_WIDTH-1:0] xlen_t;      // one machine word
  typedef logic [`CSR_ADDRW-1:0] csr_addr_t;  // csr address field of the instruction

  // matches the low two funct3 bits of csrrw / csrrs / csrrc
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

endpackage

// File: csr_top.sv
`include "csr_consts.svh"

module csr_top (
  input  logic               i_clk,
  input  logic               i_rst,

  // csr instruction
  input  logic               i_csr_valid,
  input  csr_pkg::csr_op_e   i_csr_op,
  input  csr_pkg::csr_addr_t i_csr_addr,
  input  csr_pkg::xlen_t     i_csr_src,

  // retire with trap qualifiers
  input  logic               i_retire,
  input  csr_pkg::xlen_t     i_pc,
  input  logic               i_ecall,
  input  logic               i_mret,

  // timer register writes
  input  logic               i_clint_wen,
  input  logic               i_clint_sel,
  input  csr_pkg::xlen_t     i_clint_wdata,

  output csr_pkg::xlen_t     o_csr_rdata,
  output logic               o_redirect,
  output csr_pkg::xlen_t     o_redirect_pc
);

  logic               csr_wen;
  csr_pkg::csr_addr_t csr_waddr;
  csr_pkg::xlen_t     csr_wdata;

  csr_pkg::xlen_t     mtvec;
  csr_pkg::xlen_t     mepc;
  csr_pkg::xlen_t     mstatus;
  csr_pkg::xlen_t     mie;
  csr_pkg::xlen_t     mip;

  logic               mepc_wen;
  csr_pkg::xlen_t     mepc_wdata;
  logic               mcause_wen;
  csr_pkg::xlen_t     mcause_wdata;
  logic               mstatus_wen;
  csr_pkg::xlen_t     mstatus_wdata;

  logic               mtip;

  csr_alu csr_alu_i (
    .i_valid (i_csr_valid),
    .i_op    (i_csr_op),
    .i_addr  (i_csr_addr),
    .i_src   (i_csr_src),
    .i_old   (o_csr_rdata),  // old value read this cycle
    .o_wen   (csr_wen),
    .o_waddr (csr_waddr),
    .o_wdata (csr_wdata)
  );

  csrfile csrfile_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_ren           (i_csr_valid),
    .i_raddr         (i_csr_addr),
    .o_rdata         (o_csr_rdata),
    .i_wen           (csr_wen),
    .i_waddr         (csr_waddr),
    .i_wdata         (csr_wdata),
    .i_mepc_wen      (mepc_wen),
    .i_mepc_wdata    (mepc_wdata),
    .i_mcause_wen    (mcause_wen),
    .i_mcause_wdata  (mcause_wdata),
    .i_mstatus_wen   (mstatus_wen),
    .i_mstatus_wdata (mstatus_wdata),
    .i_clint_mtip    (mtip),
    .o_mtvec         (mtvec),
    .o_mepc          (mepc),
    .o_mstatus       (mstatus),
    .o_mie           (mie),
    .o_mip           (mip)
  );

  clint clint_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_wen   (i_clint_wen),
    .i_sel   (i_clint_sel),
    .i_wdata (i_clint_wdata),
    .o_mtip  (mtip)
  );

  trap_ctrl trap_ctrl_i (
    .i_retire        (i_retire),
    .i_pc            (i_pc),
    .i_ecall         (i_ecall),
    .i_mret          (i_mret),
    .i_mtvec         (mtvec),
    .i_mepc          (mepc),
    .i_mstatus       (mstatus),
    .i_mie           (mie),
    .i_mip           (mip),
    .o_mepc_wen      (mepc_wen),
    .o_mepc_wdata    (mepc_wdata),
    .o_mcause_wen    (mcause_wen),
    .o_mcause_wdata  (mcause_wdata),
    .o_mstatus_wen   (mstatus_wen),
    .o_mstatus_wdata (mstatus_wdata),
    .o_redirect      (o_redirect),
    .o_redirect_pc   (o_redirect_pc)
  );

endmodule

// File: csrfile.sv
`include "csr_consts.svh"

module csrfile (
  input  logic               i_clk,
  input  logic               i_rst,

  // csr instruction read port
  input  logic               i_ren,
  input  csr_pkg::csr_addr_t i_raddr,
  output csr_pkg::xlen_t     o_rdata,

  // csr instruction write port
  input  logic               i_wen,
  input  csr_pkg::csr_addr_t i_waddr,
  input  csr_pkg::xlen_t     i_wdata,

  // trap ports, these beat a software write
  input  logic               i_mepc_wen,
  input  csr_pkg::xlen_t     i_mepc_wdata,
  input  logic               i_mcause_wen,
  input  csr_pkg::xlen_t     i_mcause_wdata,
  input  logic               i_mstatus_wen,
  input  csr_pkg::xlen_t     i_mstatus_wdata,

  input  logic               i_clint_mtip,

  // state seen by the trap controller
  output csr_pkg::xlen_t     o_mtvec,
  output csr_pkg::xlen_t     o_mepc,
  output csr_pkg::xlen_t     o_mstatus,
  output csr_pkg::xlen_t     o_mie,
  output csr_pkg::xlen_t     o_mip
);

  csr_pkg::xlen_t        mepc;
  csr_pkg::xlen_t        mtvec;
  csr_pkg::xlen_t        mcause;
  csr_pkg::xlen_t        mstatus;
  csr_pkg::xlen_t        mcycle;
  csr_pkg::xlen_t        mie;
  csr_pkg::xlen_t        mip;
  csr_pkg::xlen_t        mscratch;
  logic [`CPU_WIDTH-2:0] mip_rest;  // mip without the mtip bit

  logic sw_mepc;
  logic sw_mtvec;
  logic sw_mcause;
  logic sw_mstatus;
  logic sw_mcycle;
  logic sw_mie;
  logic sw_mip;
  logic sw_mscratch;

  csr_pkg::xlen_t mepc_din;
  csr_pkg::xlen_t mcause_din;
  csr_pkg::xlen_t mstatus_raw;
  csr_pkg::xlen_t mstatus_din;
  csr_pkg::xlen_t mcycle_din;
  logic           mstatus_sd;

  // software write decode
  assign sw_mepc     = i_wen && (i_waddr == `ADDR_MEPC);
  assign sw_mtvec    = i_wen && (i_waddr == `ADDR_MTVEC);
  assign sw_mcause   = i_wen && (i_waddr == `ADDR_MCAUSE);
  assign sw_mstatus  = i_wen && (i_waddr == `ADDR_MSTATUS);
  assign sw_mcycle   = i_wen && (i_waddr == `ADDR_MCYCLE);
  assign sw_mie      = i_wen && (i_waddr == `ADDR_MIE);
  assign sw_mip      = i_wen && (i_waddr == `ADDR_MIP);
  assign sw_mscratch = i_wen && (i_waddr == `ADDR_MSCRATCH);

  always_comb begin
    o_rdata = '0;
    if (i_ren) begin
      case (i_raddr)
        `ADDR_MEPC:     o_rdata = mepc;
        `ADDR_MTVEC:    o_rdata = mtvec;
        `ADDR_MCAUSE:   o_rdata = mcause;
        `ADDR_MSTATUS:  o_rdata = mstatus;
        `ADDR_MCYCLE:   o_rdata = mcycle;
        `ADDR_MIE:      o_rdata = mie;
        `ADDR_MIP:      o_rdata = mip;
        `ADDR_MSCRATCH: o_rdata = mscratch;
        default:        o_rdata = '0;  // unmapped
      endcase
    end
  end

  assign mepc_din   = i_mepc_wen   ? i_mepc_wdata   : i_wdata;
  assign mcause_din = i_mcause_wen ? i_mcause_wdata : i_wdata;

  // sd summarises the fs / vs / xs dirty state
  assign mstatus_raw = i_mstatus_wen ? i_mstatus_wdata : i_wdata;
  assign mstatus_sd  = (|mstatus_raw[`M_STATUS_FS]) | (|mstatus_raw[`M_STATUS_VS]) |
                       (|mstatus_raw[`M_STATUS_XS]);
  assign mstatus_din = {mstatus_sd, mstatus_raw[`M_STATUS_SD-1:0]};

  assign mcycle_din = sw_mcycle ? i_wdata : mcycle + `CPU_WIDTH'd1;  // free running

  stl_reg #(.T(csr_pkg::xlen_t), .RESET_VAL('0)) mepc_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (sw_mepc || i_mepc_wen),
    .i_din  (mepc_din),
    .o_dout (mepc)
  );

  stl_reg #(.T(csr_pkg::xlen_t), .RESET_VAL('0)) mtvec_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (sw_mtvec),
    .i_din  (i_wdata),
    .o_dout (mtvec)
  );

  stl_reg #(.T(csr_pkg::xlen_t), .RESET_VAL('0)) mcause_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (sw_mcause || i_mcause_wen),
    .i_din  (mcause_din),
    .o_dout (mcause)
  );

  stl_reg #(.T(csr_pkg::xlen_t), .RESET_VAL('0)) mstatus_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (sw_mstatus || i_mstatus_wen),
    .i_din  (mstatus_din),
    .o_dout (mstatus)
  );

  stl_reg #(.T(csr_pkg::xlen_t), .RESET_VAL('0)) mcycle_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (1'b1),
    .i_din  (mcycle_din),
    .o_dout (mcycle)
  );

  stl_reg #(.T(csr_pkg::xlen_t), .RESET_VAL('0)) mie_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (sw_mie),
    .i_din  (i_wdata),
    .o_dout (mie)
  );

  // bit 7 is not stored, it comes live from the clint
  stl_reg #(.T(logic [`CPU_WIDTH-2:0]), .RESET_VAL('0)) mip_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (sw_mip),
    .i_din  ({i_wdata[`CPU_WIDTH-1:`M_MIP_MTIP+1], i_wdata[`M_MIP_MTIP-1:0]}),
    .o_dout (mip_rest)
  );

  assign mip = {mip_rest[`CPU_WIDTH-2:`M_MIP_MTIP], i_clint_mtip, mip_rest[`M_MIP_MTIP-1:0]};

  stl_reg #(.T(csr_pkg::xlen_t), .RESET_VAL('0)) mscratch_reg (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_wen  (sw_mscratch),
    .i_din  (i_wdata),
    .o_dout (mscratch)
  );

  assign o_mtvec   = mtvec;
  assign o_mepc    = mepc;
  assign o_mstatus = mstatus;
  assign o_mie     = mie;
  assign o_mip     = mip;

  // the alu must hand over a clean address with every write strobe
  a_waddr_known: assert property (
    @(posedge i_clk) disable iff (i_rst) i_wen |-> !$isunknown(i_waddr)
  ) else $error("csrfile: write strobe with unknown address");

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile the CSR block testbench with Verilator and run it.
# Exit status is 0 only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_csr_top -f all.f -o sim_csr_top; then
  echo "verilator build error"
  exit 1
fi

out=$(./obj_dir/sim_csr_top)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: stl_reg.sv
module stl_reg #(
  parameter type T         = logic,
  parameter T    RESET_VAL = '0
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_wen,
  input  T     i_din,
  output T     o_dout
);

  // holds its value until written
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_dout <= RESET_VAL;
    end else if (i_wen) begin
      o_dout <= i_din;
    end
  end

endmodule

// File: tb_csr_top.sv
`include "csr_consts.svh"

module tb_csr_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RW     = 300;
  localparam int N_MCYCLE = 200;
  localparam int N_ECALL  = 40;  // 5 cycles each
  localparam int N_MRET   = 40;  // 4 cycles each
  localparam int N_TIMER  = 300;
  localparam int TIMEOUT_CYCLES = 5 + N_RW + N_MCYCLE + 5 * N_ECALL + 4 * N_MRET +
                                  (4 + N_TIMER) + 14 + 200;

  localparam logic [1:0] TK_NONE  = 2'd0;
  localparam logic [1:0] TK_INTR  = 2'd1;
  localparam logic [1:0] TK_ECALL = 2'd2;
  localparam logic [1:0] TK_MRET  = 2'd3;

  logic               clk = 1'b0;
  logic               i_rst;
  logic               i_csr_valid;
  csr_pkg::csr_op_e   i_csr_op;
  csr_pkg::csr_addr_t i_csr_addr;
  csr_pkg::xlen_t     i_csr_src;
  logic               i_retire;
  csr_pkg::xlen_t     i_pc;
  logic               i_ecall;
  logic               i_mret;
  logic               i_clint_wen;
  logic               i_clint_sel;
  csr_pkg::xlen_t     i_clint_wdata;
  csr_pkg::xlen_t     o_csr_rdata;
  logic               o_redirect;
  csr_pkg::xlen_t     o_redirect_pc;

  // values for the next cycle, driven by tick
  logic               s_rst;
  logic               s_csr_valid;
  csr_pkg::csr_op_e   s_csr_op;
  csr_pkg::csr_addr_t s_csr_addr;
  csr_pkg::xlen_t     s_csr_src;
  logic               s_retire;
  csr_pkg::xlen_t     s_pc;
  logic               s_ecall;
  logic               s_mret;
  logic               s_clint_wen;
  logic               s_clint_sel;
  csr_pkg::xlen_t     s_clint_wdata;

  // reference model state
  csr_pkg::xlen_t m_mepc, m_mtvec, m_mcause, m_mstatus;
  csr_pkg::xlen_t m_mcycle, m_mie, m_mip_rest, m_mscratch;
  csr_pkg::xlen_t m_mtime, m_mtimecmp;
  logic           m_mtip;

  logic [63:0] rng_state = 64'd19448;
  string       test_name;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_tests = 0;
  int          t_checks;
  int          t_errors;
  int          n_intr;

  always #2 clk = ~clk;

  csr_top csr_top_i (
    .i_clk         (clk),
    .i_rst         (i_rst),
    .i_csr_valid   (i_csr_valid),
    .i_csr_op      (i_csr_op),
    .i_csr_addr    (i_csr_addr),
    .i_csr_src     (i_csr_src),
    .i_retire      (i_retire),
    .i_pc          (i_pc),
    .i_ecall       (i_ecall),
    .i_mret        (i_mret),
    .i_clint_wen   (i_clint_wen),
    .i_clint_sel   (i_clint_sel),
    .i_clint_wdata (i_clint_wdata),
    .o_csr_rdata   (o_csr_rdata),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

  function automatic logic [63:0] next_rand();
    logic [63:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    rng_state = x;
    return x;
  endfunction

  function automatic csr_pkg::csr_addr_t pick_addr(logic [2:0] k);
    case (k)
      3'd0:    return `ADDR_MEPC;
      3'd1:    return `ADDR_MTVEC;
      3'd2:    return `ADDR_MCAUSE;
      3'd3:    return `ADDR_MSTATUS;
      3'd4:    return `ADDR_MCYCLE;
      3'd5:    return `ADDR_MIE;
      3'd6:    return `ADDR_MIP;
      default: return `ADDR_MSCRATCH;
    endcase
  endfunction

  function automatic csr_pkg::csr_op_e pick_op(logic [1:0] k);
    if (k == 2'd1) return csr_pkg::CSR_RS;
    if (k == 2'd2) return csr_pkg::CSR_RC;
    return csr_pkg::CSR_RW;
  endfunction

  function automatic csr_pkg::xlen_t model_read(csr_pkg::csr_addr_t addr);
    csr_pkg::xlen_t v;
    case (addr)
      `ADDR_MEPC:     v = m_mepc;
      `ADDR_MTVEC:    v = m_mtvec;
      `ADDR_MCAUSE:   v = m_mcause;
      `ADDR_MSTATUS:  v = m_mstatus;
      `ADDR_MCYCLE:   v = m_mcycle;
      `ADDR_MIE:      v = m_mie;
      `ADDR_MIP: begin
        v = m_mip_rest;
        v[`M_MIP_MTIP] = m_mtip;  // live timer bit
      end
      `ADDR_MSCRATCH: v = m_mscratch;
      default:        v = 64'd0;
    endcase
    return v;
  endfunction

  // sd follows the dirty fields on every write
  function automatic csr_pkg::xlen_t sd_fix(csr_pkg::xlen_t v);
    csr_pkg::xlen_t r;
    r = v;
    r[`M_STATUS_SD] = (|v[`M_STATUS_FS]) | (|v[`M_STATUS_VS]) | (|v[`M_STATUS_XS]);
    return r;
  endfunction

  function automatic logic [1:0] trap_kind(logic retire, logic ecall, logic mret);
    if (!retire) return TK_NONE;
    if (m_mstatus[`M_STATUS_MIE] && m_mie[`M_MIE_MTIE] && m_mtip) return TK_INTR;
    if (ecall) return TK_ECALL;
    if (mret) return TK_MRET;
    return TK_NONE;
  endfunction

  // advances the model by the edge that just happened
  task automatic model_update();
    logic [1:0]     kind;
    csr_pkg::xlen_t old;
    csr_pkg::xlen_t wdata;
    csr_pkg::xlen_t st;
    logic           sw;
    if (i_rst) begin
      m_mepc = '0;
      m_mtvec = '0;
      m_mcause = '0;
      m_mstatus = '0;
      m_mcycle = '0;
      m_mie = '0;
      m_mip_rest = '0;
      m_mscratch = '0;
      m_mtime = '0;
      m_mtimecmp = '1;
      m_mtip = 1'b0;
    end else begin
      kind = trap_kind(i_retire, i_ecall, i_mret);
      old  = model_read(i_csr_addr);
      sw   = i_csr_valid;
      case (i_csr_op)
        csr_pkg::CSR_RW: wdata = i_csr_src;
        csr_pkg::CSR_RS: wdata = old | i_csr_src;
        default:         wdata = old & ~i_csr_src;
      endcase
      st = m_mstatus;
      if (kind == TK_INTR || kind == TK_ECALL) begin
        st[`M_STATUS_MPIE] = m_mstatus[`M_STATUS_MIE];
        st[`M_STATUS_MIE]  = 1'b0;
        st[`M_STATUS_MPP]  = 2'b11;
        m_mepc    = i_pc;
        m_mcause  = (kind == TK_INTR) ? `CAUSE_MTIMER : `CAUSE_ECALL_M;
        m_mstatus = sd_fix(st);
      end else if (kind == TK_MRET) begin
        st[`M_STATUS_MIE]  = m_mstatus[`M_STATUS_MPIE];
        st[`M_STATUS_MPIE] = 1'b1;
        m_mstatus = sd_fix(st);
      end
      if (kind == TK_NONE || kind == TK_MRET) begin  // trap port wins otherwise
        if (sw && i_csr_addr == `ADDR_MEPC) m_mepc = wdata;
        if (sw && i_csr_addr == `ADDR_MCAUSE) m_mcause = wdata;
      end
      if (kind == TK_NONE && sw && i_csr_addr == `ADDR_MSTATUS) m_mstatus = sd_fix(wdata);
      if (sw && i_csr_addr == `ADDR_MTVEC) m_mtvec = wdata;
      if (sw && i_csr_addr == `ADDR_MIE) m_mie = wdata;
      if (sw && i_csr_addr == `ADDR_MSCRATCH) m_mscratch = wdata;
      if (sw && i_csr_addr == `ADDR_MIP) begin
        m_mip_rest = wdata;
        m_mip_rest[`M_MIP_MTIP] = 1'b0;
      end
      m_mcycle = (sw && i_csr_addr == `ADDR_MCYCLE) ? wdata : m_mcycle + 64'd1;
      m_mtip = (m_mtime >= m_mtimecmp);  // one cycle behind the compare
      if (i_clint_wen && i_clint_sel == `CLINT_SEL_MTIMECMP) m_mtimecmp = i_clint_wdata;
      m_mtime = (i_clint_wen && i_clint_sel == `CLINT_SEL_MTIME) ? i_clint_wdata
                                                                   : m_mtime + 64'd1;
    end
  endtask

  task automatic check_value(string what, logic [63:0] exp, logic [63:0] got);
    t_checks++;
    assert (got === exp) else begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, got);
      t_errors++;
    end
  endtask

  task automatic clear_stage();
    s_rst = 1'b0;
    s_csr_valid = 1'b0;
    s_csr_op = csr_pkg::CSR_RW;
    s_csr_addr = '0;
    s_csr_src = '0;
    s_retire = 1'b0;
    s_pc = '0;
    s_ecall = 1'b0;
    s_mret = 1'b0;
    s_clint_wen = 1'b0;
    s_clint_sel = 1'b0;
    s_clint_wdata = '0;
  endtask

  // one clock: model step, drive, then check mid-cycle
  task automatic tick();
    logic [1:0]     kind;
    csr_pkg::xlen_t exp_rd;
    @(posedge clk);
    model_update();
    i_rst <= s_rst;
    i_csr_valid <= s_csr_valid;
    i_csr_op <= s_csr_op;
    i_csr_addr <= s_csr_addr;
    i_csr_src <= s_csr_src;
    i_retire <= s_retire;
    i_pc <= s_pc;
    i_ecall <= s_ecall;
    i_mret <= s_mret;
    i_clint_wen <= s_clint_wen;
    i_clint_sel <= s_clint_sel;
    i_clint_wdata <= s_clint_wdata;
    @(negedge clk);
    exp_rd = s_csr_valid ? model_read(s_csr_addr) : 64'd0;
    kind = trap_kind(s_retire, s_ecall, s_mret);
    check_value("csr rdata", exp_rd, o_csr_rdata);
    check_value("redirect", {63'd0, kind != TK_NONE}, {63'd0, o_redirect});
    if (kind == TK_INTR) n_intr++;
    if (kind == TK_INTR || kind == TK_ECALL) begin
      check_value("redirect pc", {m_mtvec[63:2], 2'b00}, o_redirect_pc);
    end else if (kind == TK_MRET) begin
      check_value("redirect pc", m_mepc, o_redirect_pc);
    end
    clear_stage();
  endtask

  task automatic csr_cycle(csr_pkg::csr_op_e op, csr_pkg::csr_addr_t addr,
                           csr_pkg::xlen_t src);
    s_csr_valid = 1'b1;
    s_csr_op = op;
    s_csr_addr = addr;
    s_csr_src = src;
    tick();
  endtask

  task automatic retire_cycle(csr_pkg::xlen_t pc, logic ecall, logic mret);
    s_retire = 1'b1;
    s_pc = pc;
    s_ecall = ecall;
    s_mret = mret;
    tick();
  endtask

  task automatic clint_cycle(logic sel, csr_pkg::xlen_t data);
    s_clint_wen = 1'b1;
    s_clint_sel = sel;
    s_clint_wdata = data;
    tick();
  endtask

  task automatic do_reset();
    for (int i = 0; i < 4; i++) begin
      s_rst = 1'b1;
      tick();
    end
    tick();  // release
  endtask

  task automatic start_test(string name);
    test_name = name;
    t_checks = 0;
    t_errors = 0;
    n_intr = 0;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", test_name, t_checks, t_errors);
    n_checks += t_checks;
    n_errors += t_errors;
    n_tests++;
  endtask

  task automatic run_rw_test();
    logic [63:0]        r;
    csr_pkg::csr_addr_t addr;
    start_test("rw");
    for (int i = 0; i < N_RW; i++) begin
      r = next_rand();
      addr = (r[5:3] == 3'd0) ? r[27:16] : pick_addr(r[8:6]);  // some unmapped
      csr_cycle(pick_op(r[1:0]), addr, next_rand());
    end
    end_test();
  endtask

  task automatic run_mcycle_test();
    logic [63:0] r;
    start_test("mcycle");
    for (int i = 0; i < N_MCYCLE; i++) begin
      r = next_rand();
      if (r[4:0] == 5'd0) begin
        csr_cycle(csr_pkg::CSR_RW, `ADDR_MCYCLE, {32'd0, r[63:32]});
      end else if (r[1]) begin
        csr_cycle(csr_pkg::CSR_RS, `ADDR_MCYCLE, 64'd0);
      end else begin
        tick();
      end
    end
    end_test();
  endtask

  task automatic run_ecall_test();
    start_test("ecall");
    for (int i = 0; i < N_ECALL; i++) begin
      csr_cycle(csr_pkg::CSR_RW, `ADDR_MTVEC, next_rand());
      retire_cycle(next_rand(), 1'b1, 1'b0);
      csr_cycle(csr_pkg::CSR_RS, `ADDR_MEPC, 64'd0);
      csr_cycle(csr_pkg::CSR_RS, `ADDR_MCAUSE, 64'd0);
      csr_cycle(csr_pkg::CSR_RS, `ADDR_MSTATUS, 64'd0);
    end
    end_test();
  endtask

  task automatic run_mret_test();
    start_test("mret");
    for (int i = 0; i < N_MRET; i++) begin
      csr_cycle(csr_pkg::CSR_RW, `ADDR_MSTATUS, next_rand());
      csr_cycle(csr_pkg::CSR_RW, `ADDR_MEPC, next_rand());
      retire_cycle(next_rand(), 1'b0, 1'b1);
      csr_cycle(csr_pkg::CSR_RS, `ADDR_MSTATUS, 64'd0);
    end
    end_test();
  endtask

  task automatic run_timer_test();
    logic [63:0] r;
    start_test("timer");
    csr_cycle(csr_pkg::CSR_RS, `ADDR_MSTATUS, 64'h8);
    csr_cycle(csr_pkg::CSR_RS, `ADDR_MIE, 64'h80);
    clint_cycle(`CLINT_SEL_MTIME, 64'd0);
    clint_cycle(`CLINT_SEL_MTIMECMP, 64'd20);
    for (int i = 0; i < N_TIMER; i++) begin
      r = next_rand();
      case (r[2:0])
        3'd0, 3'd1, 3'd2: retire_cycle(next_rand(), 1'b0, 1'b0);
        3'd3:    csr_cycle(csr_pkg::CSR_RS, `ADDR_MIP, 64'd0);
        3'd4:    csr_cycle(csr_pkg::CSR_RS, `ADDR_MSTATUS, 64'h8);  // re-arm mie
        3'd5:    clint_cycle(`CLINT_SEL_MTIMECMP, m_mtime + {58'd0, r[13:8]});
        default: tick();
      endcase
    end
    assert (n_intr > 0) else begin
      $display("no timer interrupt was taken during test %s", test_name);
      t_errors++;
    end
    end_test();
  endtask

  task automatic run_reset_test();
    csr_pkg::csr_addr_t addr;
    start_test("reset");
    do_reset();
    retire_cycle(next_rand(), 1'b0, 1'b0);  // plain retire must not trap
    check_value("redirect after reset", 64'd0, {63'd0, o_redirect});
    for (int k = 0; k < 8; k++) begin
      addr = pick_addr(k[2:0]);
      csr_cycle(csr_pkg::CSR_RS, addr, 64'd0);
      if (addr != `ADDR_MCYCLE) check_value("reset value", 64'd0, o_csr_rdata);
    end
    end_test();
  endtask

  initial begin
    i_rst <= 1'b1;
    i_csr_valid <= 1'b0;
    i_csr_op <= csr_pkg::CSR_RW;
    i_csr_addr <= '0;
    i_csr_src <= '0;
    i_retire <= 1'b0;
    i_pc <= '0;
    i_ecall <= 1'b0;
    i_mret <= 1'b0;
    i_clint_wen <= 1'b0;
    i_clint_sel <= 1'b0;
    i_clint_wdata <= '0;
    clear_stage();
    test_name = "startup";
    t_checks = 0;
    t_errors = 0;
    do_reset();
    n_checks += t_checks;
    n_errors += t_errors;
    run_rw_test();
    run_mcycle_test();
    run_ecall_test();
    run_mret_test();
    run_timer_test();
    run_reset_test();
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_count);
    $display("sim failed");
    $finish;
  end

endmodule

// File: trap_ctrl.sv
`include "csr_consts.svh"

module trap_ctrl (
  input  logic           i_retire,
  input  csr_pkg::xlen_t i_pc,       // pc of the next instruction
  input  logic           i_ecall,
  input  logic           i_mret,
  input  csr_pkg::xlen_t i_mtvec,
  input  csr_pkg::xlen_t i_mepc,
  input  csr_pkg::xlen_t i_mstatus,
  input  csr_pkg::xlen_t i_mie,
  input  csr_pkg::xlen_t i_mip,
  output logic           o_mepc_wen,
  output csr_pkg::xlen_t o_mepc_wdata,
  output logic           o_mcause_wen,
  output csr_pkg::xlen_t o_mcause_wdata,
  output logic           o_mstatus_wen,
  output csr_pkg::xlen_t o_mstatus_wdata,
  output logic           o_redirect,
  output csr_pkg::xlen_t o_redirect_pc
);

  logic           take_intr;
  logic           take_ecall;
  logic           take_mret;
  logic           take_trap;
  csr_pkg::xlen_t mstatus_trap;
  csr_pkg::xlen_t mstatus_mret;

  // timer first, then ecall, then mret
  assign take_intr  = i_retire && i_mstatus[`M_STATUS_MIE] && i_mie[`M_MIE_MTIE] &&
                      i_mip[`M_MIP_MTIP];
  assign take_ecall = i_retire && i_ecall && !take_intr;
  assign take_mret  = i_retire && i_mret && !i_ecall && !take_intr;
  assign take_trap  = take_intr || take_ecall;

  always_comb begin
    mstatus_trap                 = i_mstatus;
    mstatus_trap[`M_STATUS_MPIE] = i_mstatus[`M_STATUS_MIE];
    mstatus_trap[`M_STATUS_MIE]  = 1'b0;
    mstatus_trap[`M_STATUS_MPP]  = 2'b11;  // trap taken from m-mode
  end

  always_comb begin
    mstatus_mret                 = i_mstatus;
    mstatus_mret[`M_STATUS_MIE]  = i_mstatus[`M_STATUS_MPIE];
    mstatus_mret[`M_STATUS_MPIE] = 1'b1;
  end

  assign o_mepc_wen   = take_trap;
  assign o_mepc_wdata = i_pc;

  assign o_mcause_wen   = take_trap;
  assign o_mcause_wdata = take_intr ? `CAUSE_MTIMER : `CAUSE_ECALL_M;

  assign o_mstatus_wen   = take_trap || take_mret;
  assign o_mstatus_wdata = take_mret ? mstatus_mret : mstatus_trap;

  // direct mode only, base is 4 byte aligned
  assign o_redirect    = take_trap || take_mret;
  assign o_redirect_pc = take_trap ? {i_mtvec[`CPU_WIDTH-1:2], 2'b00} : i_mepc;

  // decode never flags one instruction as both
  always_comb begin
    if (i_retire) begin
      a_ecall_mret_excl: assert final (!(i_ecall && i_mret))
        else $error("trap_ctrl: ecall and mret on the same retire");
    end
  end

endmodule
